/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Geometry of both caches
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 3;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 23;
    localparam logic [OFFSET_W-1:0] COUNT_FINISH = 3'd7;

    typedef struct packed {
        logic [TAG_W-1:0]                             tag;
        logic [INDEX_W-1:0]                           index;
        logic [OFFSET_W-1:0]                          word;
        logic [ADDR_W-TAG_W-INDEX_W-OFFSET_W-1:0]     byte_off;
    } addr_split_t;

    // Flat on the core and bus side, split inside the arrays
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        addr_split_t       split;
    } cache_addr_u;

    typedef enum logic [2:0] {
        STAT_NORMAL        = 3'd0,
        STAT_IC_MISS       = 3'd1,
        STAT_DC_MISS       = 3'd2,
        STAT_DC_MISS_D     = 3'd3,
        STAT_DOUBLE_MISS   = 3'd4,
        STAT_DOUBLE_MISS_D = 3'd5
    } cache_status_e;

    typedef enum logic [1:0] {
        SEL_IC_FILL   = 2'b00,
        SEL_DC_FILL   = 2'b01,
        SEL_DC_VICTIM = 2'b11
    } ram_sel_e;

    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
    } ic_req_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        cache_addr_u           addr;
        logic [WORD_W-1:0]     wdata;
        logic [WORD_W/8-1:0]   be;
    } dc_req_t;

    typedef struct packed {
        logic              ready;
        logic [WORD_W-1:0] rdata;
    } core_rsp_t;

endpackage

`default_nettype wire

/* design/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // Master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* design/cache_way.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_way (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::cache_addr_u addr,
    input  logic [2:0]             word_sel,
    input  logic                   enable,
    input  logic                   cmp,
    input  logic                   write,
    input  logic                   valid_in,
    input  logic [3:0]             byte_en,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata,
    output logic                   hit,
    output logic                   valid,
    output logic                   dirty,
    output logic [22:0]            victim_tag
);
    import cache_pkg::*;

    logic [WORD_W-1:0]     data_mem [2**INDEX_W][LINE_WORDS];
    logic [TAG_W-1:0]      tag_mem  [2**INDEX_W];
    logic [2**INDEX_W-1:0] valid_q;
    logic [2**INDEX_W-1:0] dirty_q;
    logic [INDEX_W-1:0]    index;
    logic                  store;
    logic                  fill;

    assign index = addr.split.index;

    // Asynchronous read of the indexed line
    assign rdata      = data_mem[index][word_sel];
    assign valid      = valid_q[index];
    assign dirty      = dirty_q[index];
    assign victim_tag = tag_mem[index];
    assign hit        = enable && (tag_mem[index] == addr.split.tag);

    assign store = enable && write;
    assign fill  = store && !cmp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[index] <= valid_in;
            dirty_q[index] <= 1'b0;
        end else if (store) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index] <= addr.split.tag;
        end
        if (store) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (byte_en[b]) begin
                    data_mem[index][word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Controller only issues compare writes on a valid hit
    ////////////////////////////////////////////////////////////
    a_cmp_write_hits: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enable && write && cmp) |-> (hit && valid)
    );

endmodule

`default_nettype wire

/* design/cache_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_control (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::ic_req_t  ic_req,
    input  cache_pkg::dc_req_t  dc_req,
    input  logic                ic_hit,
    input  logic                ic_valid,
    input  logic                dc_hit,
    input  logic                dc_valid,
    input  logic                dc_dirty,
    input  logic                word_done,
    output logic                ic_enable,
    output logic                ic_cmp,
    output logic                ic_write,
    output logic                ic_valid_in,
    output logic [2:0]          ic_word_sel,
    output logic [3:0]          ic_byte_en,
    output logic                dc_enable,
    output logic                dc_cmp,
    output logic                dc_write,
    output logic                dc_valid_in,
    output logic [2:0]          dc_word_sel,
    output logic [3:0]          dc_byte_en,
    output logic                ic_addr_src,
    output logic                dc_addr_src,
    output logic                ram_en,
    output logic                ram_write,
    output cache_pkg::ram_sel_e ram_sel,
    output logic                ic_rsp_ready,
    output logic                dc_rsp_ready
);
    import cache_pkg::*;

    cache_status_e       status_q;
    cache_status_e       status_d;
    logic [OFFSET_W-1:0] count_q;
    logic [OFFSET_W-1:0] count_d;
    logic                ic_hit_ok;
    logic                dc_hit_ok;
    logic                ic_miss;
    logic                dc_miss;
    logic                coh_hit;
    logic                step;

    assign ic_hit_ok = ic_hit && ic_valid;
    assign dc_hit_ok = dc_hit && dc_valid;
    assign ic_miss   = ic_req.valid && !ic_hit_ok;
    assign dc_miss   = (dc_req.read || dc_req.write) && !dc_hit_ok;

    // Fetch refill served from the data cache one word per cycle
    assign coh_hit = (status_q inside {STAT_IC_MISS, STAT_DOUBLE_MISS}) && dc_hit_ok;
    assign step    = word_done || coh_hit;

    assign ic_rsp_ready = (status_q == STAT_NORMAL) && ic_req.valid && ic_hit_ok;
    assign dc_rsp_ready = (status_q == STAT_NORMAL) && (dc_req.read || dc_req.write) && dc_hit_ok;

    always_comb begin
        ic_enable   = 1'b0;
        ic_cmp      = 1'b0;
        ic_write    = 1'b0;
        ic_valid_in = 1'b1;
        ic_word_sel = count_q;
        ic_byte_en  = 4'b1111;
        dc_enable   = 1'b0;
        dc_cmp      = 1'b0;
        dc_write    = 1'b0;
        dc_valid_in = 1'b1;
        dc_word_sel = count_q;
        dc_byte_en  = 4'b1111;
        ic_addr_src = 1'b0;
        dc_addr_src = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_sel     = SEL_IC_FILL;
        status_d    = status_q;
        count_d     = count_q;

        case (status_q)
            STAT_IC_MISS, STAT_DOUBLE_MISS: begin
                ic_enable   = 1'b1;
                ic_write    = step;
                // Probe data cache at the fetch address
                dc_enable   = 1'b1;
                dc_cmp      = 1'b1;
                dc_addr_src = 1'b1;
                dc_byte_en  = 4'b0000;
                ram_en      = !coh_hit;
            end
            STAT_DC_MISS: begin
                dc_enable = 1'b1;
                dc_write  = word_done;
                ram_en    = 1'b1;
                ram_sel   = SEL_DC_FILL;
            end
            STAT_DC_MISS_D, STAT_DOUBLE_MISS_D: begin
                dc_enable  = 1'b1;
                dc_byte_en = 4'b0000;
                ram_en     = 1'b1;
                ram_write  = 1'b1;
                ram_sel    = SEL_DC_VICTIM;
            end
            default: begin
                ic_enable   = ic_req.valid;
                ic_cmp      = 1'b1;
                ic_word_sel = ic_req.addr.split.word;
                ic_byte_en  = 4'b0000;
                dc_enable   = dc_req.read || dc_req.write;
                dc_cmp      = 1'b1;
                dc_write    = dc_req.write && dc_hit_ok;
                dc_word_sel = dc_req.addr.split.word;
                dc_byte_en  = dc_req.be;
                if (dc_miss && ic_miss) begin
                    status_d = dc_dirty ? STAT_DOUBLE_MISS_D : STAT_DOUBLE_MISS;
                end else if (dc_miss) begin
                    status_d = dc_dirty ? STAT_DC_MISS_D : STAT_DC_MISS;
                end else if (ic_miss) begin
                    status_d = STAT_IC_MISS;
                end
                if (dc_miss || ic_miss) begin
                    count_d = '0;
                end
            end
        endcase

        // Word counter and the state after the last word of a line
        if (status_q != STAT_NORMAL && step) begin
            count_d = count_q + 3'd1;
            if (count_q == COUNT_FINISH) begin
                case (status_q)
                    STAT_DC_MISS_D:     status_d = STAT_DC_MISS;
                    STAT_DOUBLE_MISS:   status_d = STAT_DC_MISS;
                    STAT_DOUBLE_MISS_D: status_d = STAT_DOUBLE_MISS;
                    default:            status_d = STAT_NORMAL;
                endcase
                if (status_d == STAT_NORMAL) begin
                    count_d = COUNT_FINISH;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= STAT_NORMAL;
            count_q  <= COUNT_FINISH;
        end else begin
            status_q <= status_d;
            count_q  <= count_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // State and counter sanity
    ////////////////////////////////////////////////////////////
    a_status_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        status_q inside {STAT_NORMAL, STAT_IC_MISS, STAT_DC_MISS, STAT_DC_MISS_D,
                         STAT_DOUBLE_MISS, STAT_DOUBLE_MISS_D}
    );

    a_count_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(count_q) |->
            (count_q == $past(count_q) + 3'd1) || (count_q == '0) || (count_q == COUNT_FINISH)
    );

endmodule

`default_nettype wire

/* design/wb_line_master.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_line_master (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ram_en,
    input  logic                   ram_write,
    input  cache_pkg::cache_addr_u ram_addr,
    input  logic [31:0]            wdata,
    output wb_pkg::wb_req_t        wb_req,
    input  wb_pkg::wb_rsp_t        wb_rsp,
    output logic                   word_done,
    output logic [31:0]            rd_word
);
    import wb_pkg::*;

    typedef enum logic {
        M_IDLE,
        M_BUSY
    } state_e;

    state_e              state_q;
    logic                we_q;
    logic [WB_ADR_W-1:0] adr_q;
    logic [WB_DAT_W-1:0] dat_q;

    // After ack the master sits one cycle in idle with cyc low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= M_IDLE;
        end else if (state_q == M_IDLE && ram_en) begin
            state_q <= M_BUSY;
        end else if (state_q == M_BUSY && wb_rsp.ack) begin
            state_q <= M_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == M_IDLE && ram_en) begin
            we_q  <= ram_write;
            adr_q <= ram_addr.flat;
            dat_q <= wdata;
        end
    end

    assign wb_req.cyc = (state_q == M_BUSY);
    assign wb_req.stb = (state_q == M_BUSY);
    assign wb_req.we  = we_q;
    assign wb_req.adr = adr_q;
    assign wb_req.dat = dat_q;
    assign wb_req.sel = '1;

    assign word_done = (state_q == M_BUSY) && wb_rsp.ack;
    assign rd_word   = wb_rsp.dat;

    // Controller keeps its word request steady until the ack
    a_ctrl_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == M_BUSY) |->
            ram_en && (ram_write == we_q) && (ram_addr.flat == adr_q)
    );

    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)
    );

endmodule

`default_nettype wire

/* design/split_cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module split_cache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::ic_req_t   ic_req,
    input  cache_pkg::dc_req_t   dc_req,
    output cache_pkg::core_rsp_t ic_rsp,
    output cache_pkg::core_rsp_t dc_rsp,
    output wb_pkg::wb_req_t      wb_req,
    input  wb_pkg::wb_rsp_t      wb_rsp
);
    import cache_pkg::*;

    cache_addr_u       ic_addr;
    cache_addr_u       dc_addr;
    cache_addr_u       ram_addr;
    ram_sel_e          ram_sel;
    logic              ic_hit, ic_valid, dc_hit, dc_valid, dc_dirty;
    logic              ic_enable, ic_cmp, ic_write, ic_valid_in;
    logic              dc_enable, dc_cmp, dc_write, dc_valid_in;
    logic [2:0]        ic_word_sel;
    logic [2:0]        dc_word_sel;
    logic [3:0]        ic_byte_en;
    logic [3:0]        dc_byte_en;
    logic              ic_addr_src, dc_addr_src;
    logic              ram_en, ram_write, word_done;
    logic              ic_rsp_ready, dc_rsp_ready;
    logic [WORD_W-1:0] ic_rdata, dc_rdata, rd_word;
    logic [TAG_W-1:0]  victim_tag;

    assign ic_addr = ic_addr_src ? dc_req.addr : ic_req.addr;
    assign dc_addr = dc_addr_src ? ic_req.addr : dc_req.addr;

    // Bus word address for the line being moved
    always_comb begin
        case (ram_sel)
            SEL_IC_FILL: begin
                ram_addr            = ic_req.addr;
                ram_addr.split.word = ic_word_sel;
            end
            SEL_DC_FILL: begin
                ram_addr            = dc_req.addr;
                ram_addr.split.word = dc_word_sel;
            end
            default: begin
                ram_addr            = dc_req.addr;
                ram_addr.split.tag  = victim_tag;
                ram_addr.split.word = dc_word_sel;
            end
        endcase
        ram_addr.split.byte_off = '0;
    end

    assign ic_rsp.ready = ic_rsp_ready;
    assign ic_rsp.rdata = ic_rdata;
    assign dc_rsp.ready = dc_rsp_ready;
    assign dc_rsp.rdata = dc_rdata;

    cache_way u_icache (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (ic_addr),
        .word_sel   (ic_word_sel),
        .enable     (ic_enable),
        .cmp        (ic_cmp),
        .write      (ic_write),
        .valid_in   (ic_valid_in),
        .byte_en    (ic_byte_en),
        .wdata      (ram_en ? rd_word : dc_rdata),
        .rdata      (ic_rdata),
        .hit        (ic_hit),
        .valid      (ic_valid),
        .dirty      (),
        .victim_tag ()
    );

    cache_way u_dcache (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (dc_addr),
        .word_sel   (dc_word_sel),
        .enable     (dc_enable),
        .cmp        (dc_cmp),
        .write      (dc_write),
        .valid_in   (dc_valid_in),
        .byte_en    (dc_byte_en),
        .wdata      (dc_cmp ? dc_req.wdata : rd_word),
        .rdata      (dc_rdata),
        .hit        (dc_hit),
        .valid      (dc_valid),
        .dirty      (dc_dirty),
        .victim_tag (victim_tag)
    );

    cache_control u_control (.*);

    wb_line_master u_wb_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_en    (ram_en),
        .ram_write (ram_write),
        .ram_addr  (ram_addr),
        .wdata     (dc_rdata),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .word_done (word_done),
        .rd_word   (rd_word)
    );

endmodule

`default_nettype wire

/* bench/wb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_mem_model (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);
    import wb_pkg::*;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] LFSR_SEED = 32'hf774;

    logic [WB_DAT_W-1:0] mem [MEM_WORDS];
    logic [31:0]         lfsr_q;
    logic [31:0]         lfsr_1;
    logic [31:0]         lfsr_2;
    logic [1:0]          wait_q;
    logic [9:0]          word_idx;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Each word starts as its own byte address XOR a fixed pattern
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'(i * 4) ^ 32'h5a5a0000;
        end
    end

    assign word_idx = wb_req.adr[11:2];
    assign lfsr_1   = lfsr_next(lfsr_q);
    assign lfsr_2   = lfsr_next(lfsr_1);

    always @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp.ack <= 1'b0;
            lfsr_q     <= LFSR_SEED;
            wait_q     <= 2'd0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[word_idx];
                if (wb_req.we) begin
                    for (int b = 0; b < WB_SEL_W; b++) begin
                        if (wb_req.sel[b]) begin
                            mem[word_idx][8*b +: 8] <= wb_req.dat[8*b +: 8];
                        end
                    end
                end
                // Two steps, one bit each, for the next access
                wait_q <= {lfsr_2[0], lfsr_1[0]};
                lfsr_q <= lfsr_2;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_split_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_split_cache;
    import cache_pkg::*;
    import wb_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = NUM_TESTS * 40 * 5;
    localparam int MEM_WORDS   = 1024;
    localparam int DRIVE_DELAY = 2;

    logic        clk;
    logic        rst_n;
    ic_req_t     ic_req;
    dc_req_t     dc_req;
    core_rsp_t   ic_rsp;
    core_rsp_t   dc_rsp;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] ic_expect;
    logic [31:0] dc_expect;
    logic [31:0] wb_expect;
    logic [2:0]  next_read_word;
    logic [2:0]  next_write_word;
    logic [26:0] read_line;
    logic [26:0] write_line;
    logic        no_bus;
    int          reads_in_test;
    int          writes_in_test;
    int          cycle_count = 0;
    int          last_cycles;
    int          test_num;
    int          test_errors;
    int          error_total;
    int          failed_tests;
    string       test_name;

    split_cache_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .ic_req (ic_req),
        .dc_req (dc_req),
        .ic_rsp (ic_rsp),
        .dc_rsp (dc_rsp),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    wb_mem_model u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped: no finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Core view of memory kept up to date by completed stores
    ////////////////////////////////////////////////////////////
    assign ic_expect = shadow[ic_req.addr.flat[11:2]];
    assign dc_expect = shadow[dc_req.addr.flat[11:2]];
    assign wb_expect = shadow[wb_req.adr[11:2]];

    always @(posedge clk) begin
        if (rst_n && dc_req.write && dc_rsp.ready) begin
            for (int b = 0; b < 4; b++) begin
                if (dc_req.be[b]) begin
                    shadow[dc_req.addr.flat[11:2]][8*b +: 8] <= dc_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Bus word tracking
    always @(posedge clk) begin
        if (!rst_n) begin
            next_read_word  <= 3'd0;
            next_write_word <= 3'd0;
        end else if (wb_req.cyc && wb_rsp.ack) begin
            if (wb_req.we) begin
                writes_in_test  <= writes_in_test + 1;
                next_write_word <= wb_req.adr[4:2] + 3'd1;
                write_line      <= wb_req.adr[31:5];
            end else begin
                reads_in_test  <= reads_in_test + 1;
                next_read_word <= wb_req.adr[4:2] + 3'd1;
                read_line      <= wb_req.adr[31:5];
            end
        end
    end

    function automatic void count_error();
        test_errors = test_errors + 1;
        error_total = error_total + 1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!ic_req.valid && !dc_req.read && !dc_req.write) |->
            (!wb_req.cyc && !ic_rsp.ready && !dc_rsp.ready))
    else begin
        $display("%s: bus cycle or ready seen with no request pending", test_name);
        count_error();
    end

    a_no_bus: assert property (@(posedge clk) disable iff (!rst_n)
        no_bus |-> !wb_req.cyc)
    else begin
        $display("%s: bus cycle seen where the caches should serve alone", test_name);
        count_error();
    end

    a_fetch_data: assert property (@(posedge clk) disable iff (!rst_n)
        (ic_req.valid && ic_rsp.ready) |-> (ic_rsp.rdata == ic_expect))
    else begin
        $display("Fail %s: fetch expected %h actual %h",
                 test_name, $sampled(ic_expect), $sampled(ic_rsp.rdata));
        count_error();
    end

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        (dc_req.read && dc_rsp.ready) |-> (dc_rsp.rdata == dc_expect))
    else begin
        $display("Fail %s: load expected %h actual %h",
                 test_name, $sampled(dc_expect), $sampled(dc_rsp.rdata));
        count_error();
    end

    a_victim_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_rsp.ack && wb_req.we) |-> (wb_req.dat == wb_expect))
    else begin
        $display("Fail %s: write-back expected %h actual %h",
                 test_name, $sampled(wb_expect), $sampled(wb_req.dat));
        count_error();
    end

    // Write-back of a victim comes before any refill read
    a_victim_first: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_rsp.ack && wb_req.we) |-> (reads_in_test == 0))
    else begin
        $display("%s: refill read made before the victim write-back", test_name);
        count_error();
    end

    a_read_order: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_rsp.ack && !wb_req.we) |->
            (wb_req.adr[4:2] == next_read_word) &&
            (next_read_word == 3'd0 || wb_req.adr[31:5] == read_line))
    else begin
        $display("Fail %s: read word expected %0d actual %0d",
                 test_name, $sampled(next_read_word), $sampled(wb_req.adr[4:2]));
        count_error();
    end

    a_write_order: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_rsp.ack && wb_req.we) |->
            (wb_req.adr[4:2] == next_write_word) &&
            (next_write_word == 3'd0 || wb_req.adr[31:5] == write_line))
    else begin
        $display("Fail %s: write word expected %0d actual %0d",
                 test_name, $sampled(next_write_word), $sampled(wb_req.adr[4:2]));
        count_error();
    end

    a_sel_full: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> (wb_req.sel == 4'b1111))
    else begin
        $display("Fail %s: bus select expected %h actual %h",
                 test_name, 4'b1111, $sampled(wb_req.sel));
        count_error();
    end

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) &&
            $stable(wb_req.dat) && $stable(wb_req.sel))
    else begin
        $display("%s: bus request changed or dropped before ack", test_name);
        count_error();
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Holds each request until its ready is seen mid-cycle
    task automatic access(input logic fetch_on, input logic [31:0] fetch_addr,
                          input logic rd, input logic wr, input logic [31:0] data_addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        logic ic_wait;
        logic dc_wait;
        ic_wait          = fetch_on;
        dc_wait          = rd || wr;
        ic_req.valid     = fetch_on;
        ic_req.addr.flat = fetch_addr;
        dc_req.read      = rd;
        dc_req.write     = wr;
        dc_req.addr.flat = data_addr;
        dc_req.wdata     = wdata;
        dc_req.be        = be;
        last_cycles      = 0;
        while (ic_wait || dc_wait) begin
            @(negedge clk);
            last_cycles = last_cycles + 1;
            if (ic_rsp.ready) begin
                ic_wait = 1'b0;
            end
            if (dc_rsp.ready) begin
                dc_wait = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            if (!ic_wait) begin
                ic_req.valid = 1'b0;
            end
            if (!dc_wait) begin
                dc_req.read  = 1'b0;
                dc_req.write = 1'b0;
            end
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        access(1'b1, addr, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
    endtask

    task automatic load(input logic [31:0] addr);
        access(1'b0, 32'h0, 1'b1, 1'b0, addr, 32'h0, 4'h0);
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] be);
        access(1'b0, 32'h0, 1'b0, 1'b1, addr, data, be);
    endtask

    task automatic clear_bus_counts();
        reads_in_test  = 0;
        writes_in_test = 0;
    endtask

    task automatic begin_test(input string name);
        test_num    = test_num + 1;
        test_name   = name;
        test_errors = 0;
        clear_bus_counts();
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Fail %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            count_error();
        end
    endtask

    task automatic end_test();
        $display("test %0d %s: %s, %0d errors", test_num, test_name,
                 (test_errors == 0) ? "ok" : "bad", test_errors);
        if (test_errors != 0) begin
            failed_tests = failed_tests + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n        = 1'b0;
        ic_req       = '0;
        dc_req       = '0;
        no_bus       = 1'b0;
        test_num     = 0;
        test_errors  = 0;
        error_total  = 0;
        failed_tests = 0;
        test_name    = "reset";
        clear_bus_counts();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'(i * 4) ^ 32'h5a5a0000;
        end
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        begin_test("cold_fetch");
        idle(4);
        fetch(32'h0000_0000);
        check_count("bus reads", 8, reads_in_test);
        end_test();

        begin_test("partial_store");
        load(32'h0000_0100);
        no_bus = 1'b1;
        store(32'h0000_0104, 32'ha1b2c3d4, 4'b0101);
        load(32'h0000_0104);
        no_bus = 1'b0;
        check_count("bus reads", 8, reads_in_test);
        end_test();

        // Index 8 is dirty and 0x300 maps onto it
        begin_test("dirty_writeback");
        store(32'h0000_0108, 32'hcafe0108, 4'b1111);
        load(32'h0000_0304);
        load(32'h0000_0104);
        check_count("bus writes", 8, writes_in_test);
        check_count("bus reads", 16, reads_in_test);
        end_test();

        begin_test("double_miss");
        store(32'h0000_0404, 32'h0bad_f00d, 4'b1111);
        clear_bus_counts();
        access(1'b1, 32'h0000_0244, 1'b1, 1'b0, 32'h0000_0004, 32'h0, 4'h0);
        check_count("bus writes", 8, writes_in_test);
        check_count("bus reads", 16, reads_in_test);
        end_test();

        begin_test("coherent_fetch");
        no_bus = 1'b1;
        store(32'h0000_010c, 32'h1234_5678, 4'b1111);
        fetch(32'h0000_010c);
        no_bus = 1'b0;
        check_count("fetch cycles", LINE_WORDS + 2, last_cycles);
        end_test();

        begin_test("random_waits");
        fetch(32'h0000_0600);
        load(32'h0000_0520);
        store(32'h0000_0524, 32'h5eed_0524, 4'b1111);
        clear_bus_counts();
        load(32'h0000_0724);
        load(32'h0000_0524);
        check_count("bus writes", 8, writes_in_test);
        check_count("bus reads", 16, reads_in_test);
        end_test();

        idle(2);
        $display("tests run %0d, failing %0d, errors %0d", test_num, failed_tests, error_total);
        if (error_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/cache_pkg.sv
design/wb_pkg.sv
design/cache_way.sv
design/cache_control.sv
design/wb_line_master.sv
design/split_cache_top.sv
bench/wb_mem_model.sv
bench/tb_split_cache.sv

/* Bender.yml */
package:
  name: split_cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/wb_pkg.sv
      - design/cache_way.sv
      - design/cache_control.sv
      - design/wb_line_master.sv
      - design/split_cache_top.sv
  - target: test
    files:
      - bench/wb_mem_model.sv
      - bench/tb_split_cache.sv
